/* bus_pkg.sv */
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // top three address bits select the segment
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // cache attribute driven on ar/aw
    localparam logic [3:0] CACHE_CACHED   = 4'b1111;
    localparam logic [3:0] CACHE_UNCACHED = 4'b0000;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } vaddr_seg_t;

    // one virtual address word, seen raw or split into segment and offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        vaddr_seg_t        fields;
    } vaddr_u;

endpackage

/* mem_req_if.sv */
`timescale 1ns/100ps

interface mem_req_if;

    logic                        req_valid;
    logic                        req_ready;
    logic                        we;
    logic [bus_pkg::ADDR_W-1:0]  addr;
    logic [bus_pkg::DATA_W-1:0]  wdata;
    logic [bus_pkg::STRB_W-1:0]  wstrb;

    // one pulse per accepted request, rdata valid for reads only
    logic                        resp_valid;
    logic [bus_pkg::DATA_W-1:0]  rdata;

    modport requester (
        output req_valid, we, addr, wdata, wstrb,
        input  req_ready, resp_valid, rdata
    );

    modport server (
        input  req_valid, we, addr, wdata, wstrb,
        output req_ready, resp_valid, rdata
    );

endinterface

/* addr_xlate.sv */
`timescale 1ns/100ps

module addr_xlate (
    input  bus_pkg::vaddr_u             vaddr_i,
    output logic [bus_pkg::ADDR_W-1:0]  paddr_o,
    output logic                        uncached_o
);

    logic in_kseg0;
    logic in_kseg1;

    assign in_kseg0 = (vaddr_i.fields.seg == bus_pkg::SEG_KSEG0);
    assign in_kseg1 = (vaddr_i.fields.seg == bus_pkg::SEG_KSEG1);

    // kseg0 and kseg1 both fold onto physical 0x0000_0000 .. 0x1fff_ffff
    always_comb begin
        if (in_kseg0 || in_kseg1) begin
            paddr_o = {3'b000, vaddr_i.fields.offset};
        end else begin
            paddr_o = vaddr_i.raw;
        end
    end

    assign uncached_o = in_kseg1;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        inst_valid_i,
    input  logic [bus_pkg::ADDR_W-1:0]  inst_addr_i,
    output logic                        inst_ready_o,
    output logic                        inst_resp_valid_o,
    output logic [bus_pkg::DATA_W-1:0]  inst_rdata_o,

    mem_req_if.server                   data_port,
    mem_req_if.requester                bus_port
);

    logic grant_data;
    logic bus_accept;
    logic owner_data_q;

    // data port has fixed priority over instruction fetch
    assign grant_data = data_port.req_valid;

    assign bus_port.req_valid = data_port.req_valid || inst_valid_i;
    assign bus_port.we        = grant_data ? data_port.we : 1'b0;
    assign bus_port.addr      = grant_data ? data_port.addr : inst_addr_i;
    assign bus_port.wdata     = data_port.wdata;
    assign bus_port.wstrb     = grant_data ? data_port.wstrb : '0;

    // ready goes back to the granted port only
    assign data_port.req_ready = grant_data && bus_port.req_ready;
    assign inst_ready_o        = inst_valid_i && !grant_data && bus_port.req_ready;

    assign bus_accept = bus_port.req_valid && bus_port.req_ready;

    // remember who owns the outstanding transaction
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_data_q <= 1'b0;
        end else if (bus_accept) begin
            owner_data_q <= grant_data;
        end
    end

    assign data_port.resp_valid = bus_port.resp_valid && owner_data_q;
    assign inst_resp_valid_o    = bus_port.resp_valid && !owner_data_q;

    assign data_port.rdata = bus_port.rdata;
    assign inst_rdata_o    = bus_port.rdata;

endmodule

/* axi_bridge.sv */
`timescale 1ns/100ps

module axi_bridge (
    input  logic                        clk,
    input  logic                        rst,

    mem_req_if.server                   req_port,

    output logic [bus_pkg::ADDR_W-1:0]  ar_addr_o,
    output logic [3:0]                  ar_cache_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,

    input  logic [bus_pkg::DATA_W-1:0]  r_data_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,

    output logic [bus_pkg::ADDR_W-1:0]  aw_addr_o,
    output logic [3:0]                  aw_cache_o,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,

    output logic [bus_pkg::DATA_W-1:0]  w_data_o,
    output logic [bus_pkg::STRB_W-1:0]  w_strb_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,

    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    logic [bus_pkg::ADDR_W-1:0] paddr;
    logic                       uncached;

    // transaction phase flags, at most one group is set at a time
    logic ar_pend_q;
    logic r_pend_q;
    logic aw_pend_q;
    logic w_pend_q;
    logic b_pend_q;
    logic resp_q;

    logic [bus_pkg::ADDR_W-1:0] addr_q;
    logic [3:0]                 cache_q;
    logic [bus_pkg::DATA_W-1:0] wdata_q;
    logic [bus_pkg::STRB_W-1:0] wstrb_q;
    logic [bus_pkg::DATA_W-1:0] rdata_q;

    logic idle;
    logic accept;
    logic ar_fire;
    logic r_fire;
    logic b_fire;
    logic aw_left;
    logic w_left;
    logic wr_active;

    addr_xlate u_xlate (
        .vaddr_i    (req_port.addr),
        .paddr_o    (paddr),
        .uncached_o (uncached)
    );

    assign idle   = !(ar_pend_q || r_pend_q || aw_pend_q || w_pend_q || b_pend_q);
    assign accept = req_port.req_valid && idle;

    assign ar_fire = ar_pend_q && ar_ready_i;
    assign r_fire  = r_pend_q && r_valid_i;
    assign b_fire  = b_pend_q && b_valid_i;

    // aw and w complete independently, b is awaited once both are gone
    assign aw_left   = aw_pend_q && !aw_ready_i;
    assign w_left    = w_pend_q && !w_ready_i;
    assign wr_active = aw_pend_q || w_pend_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_pend_q <= 1'b0;
            r_pend_q  <= 1'b0;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            b_pend_q  <= 1'b0;
            resp_q    <= 1'b0;
        end else begin
            resp_q <= r_fire || b_fire;
            if (accept) begin
                ar_pend_q <= !req_port.we;
                aw_pend_q <= req_port.we;
                w_pend_q  <= req_port.we;
            end else begin
                if (ar_fire) begin
                    ar_pend_q <= 1'b0;
                    r_pend_q  <= 1'b1;
                end
                if (r_fire) begin
                    r_pend_q <= 1'b0;
                end
                if (wr_active) begin
                    aw_pend_q <= aw_left;
                    w_pend_q  <= w_left;
                    b_pend_q  <= !aw_left && !w_left;
                end
                if (b_fire) begin
                    b_pend_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= paddr;
            cache_q <= uncached ? bus_pkg::CACHE_UNCACHED : bus_pkg::CACHE_CACHED;
            wdata_q <= req_port.wdata;
            wstrb_q <= req_port.wstrb;
        end
        if (r_fire) begin
            rdata_q <= r_data_i;
        end
    end

    assign req_port.req_ready  = idle;
    assign req_port.resp_valid = resp_q;
    assign req_port.rdata      = rdata_q;

    assign ar_addr_o  = addr_q;
    assign ar_cache_o = cache_q;
    assign ar_valid_o = ar_pend_q;
    assign r_ready_o  = r_pend_q;

    assign aw_addr_o  = addr_q;
    assign aw_cache_o = cache_q;
    assign aw_valid_o = aw_pend_q;
    assign w_data_o   = wdata_q;
    assign w_strb_o   = wstrb_q;
    assign w_valid_o  = w_pend_q;
    assign b_ready_o  = b_pend_q;

endmodule

/* cpu_bus_unit.sv */
`timescale 1ns/100ps

module cpu_bus_unit (
    input  logic                        clk,
    input  logic                        rst,

    // instruction fetch, read only
    input  logic                        inst_valid_i,
    input  logic [bus_pkg::ADDR_W-1:0]  inst_addr_i,
    output logic                        inst_ready_o,
    output logic                        inst_resp_valid_o,
    output logic [bus_pkg::DATA_W-1:0]  inst_rdata_o,

    // load/store port
    input  logic                        data_valid_i,
    input  logic                        data_we_i,
    input  logic [bus_pkg::ADDR_W-1:0]  data_addr_i,
    input  logic [bus_pkg::DATA_W-1:0]  data_wdata_i,
    input  logic [bus_pkg::STRB_W-1:0]  data_wstrb_i,
    output logic                        data_ready_o,
    output logic                        data_resp_valid_o,
    output logic [bus_pkg::DATA_W-1:0]  data_rdata_o,

    // single-beat AXI
    output logic [bus_pkg::ADDR_W-1:0]  ar_addr_o,
    output logic [3:0]                  ar_cache_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    input  logic [bus_pkg::DATA_W-1:0]  r_data_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    output logic [bus_pkg::ADDR_W-1:0]  aw_addr_o,
    output logic [3:0]                  aw_cache_o,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic [bus_pkg::DATA_W-1:0]  w_data_o,
    output logic [bus_pkg::STRB_W-1:0]  w_strb_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    mem_req_if data_if ();
    mem_req_if bus_if ();

    assign data_if.req_valid = data_valid_i;
    assign data_if.we        = data_we_i;
    assign data_if.addr      = data_addr_i;
    assign data_if.wdata     = data_wdata_i;
    assign data_if.wstrb     = data_wstrb_i;

    assign data_ready_o      = data_if.req_ready;
    assign data_resp_valid_o = data_if.resp_valid;
    assign data_rdata_o      = data_if.rdata;

    mem_arbiter u_arbiter (
        .clk               (clk),
        .rst               (rst),
        .inst_valid_i      (inst_valid_i),
        .inst_addr_i       (inst_addr_i),
        .inst_ready_o      (inst_ready_o),
        .inst_resp_valid_o (inst_resp_valid_o),
        .inst_rdata_o      (inst_rdata_o),
        .data_port         (data_if.server),
        .bus_port          (bus_if.requester)
    );

    axi_bridge u_bridge (
        .clk        (clk),
        .rst        (rst),
        .req_port   (bus_if.server),
        .ar_addr_o  (ar_addr_o),
        .ar_cache_o (ar_cache_o),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .r_data_i   (r_data_i),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .aw_addr_o  (aw_addr_o),
        .aw_cache_o (aw_cache_o),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .w_data_o   (w_data_o),
        .w_strb_o   (w_strb_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready_i),
        .b_valid_i  (b_valid_i),
        .b_ready_o  (b_ready_o)
    );

endmodule

/* cpu_bus_unit_properties.sv */
`timescale 1ns/100ps

module bus_protocol_checker (
    input logic                        clk,
    input logic                        rst,
    input logic [bus_pkg::ADDR_W-1:0]  ar_addr_i,
    input logic [3:0]                  ar_cache_i,
    input logic                        ar_valid_i,
    input logic                        ar_ready_i,
    input logic                        r_ready_i,
    input logic [bus_pkg::ADDR_W-1:0]  aw_addr_i,
    input logic [3:0]                  aw_cache_i,
    input logic                        aw_valid_i,
    input logic                        aw_ready_i,
    input logic                        w_valid_i,
    input logic                        b_ready_i,
    input logic                        req_valid_i,
    input logic                        req_ready_i,
    input logic                        resp_valid_i
);

    logic outstanding_q;

    // one request in flight from its acceptance until its response pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            outstanding_q <= 1'b1;
        end else if (resp_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_cache_i))
        else $error("ar payload changed while waiting for ar_ready");

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_cache_i))
        else $error("aw payload changed while waiting for aw_ready");

    // read and write phases never overlap
    one_direction: assert property (@(posedge clk) disable iff (rst)
        !((ar_valid_i || r_ready_i) && (aw_valid_i || w_valid_i || b_ready_i)))
        else $error("read and write outstanding together");

    resp_when_outstanding: assert property (@(posedge clk) disable iff (rst)
        resp_valid_i |-> outstanding_q)
        else $error("response pulse without an outstanding request");

endmodule

bind axi_bridge bus_protocol_checker u_protocol_checker (
    .clk          (clk),
    .rst          (rst),
    .ar_addr_i    (ar_addr_o),
    .ar_cache_i   (ar_cache_o),
    .ar_valid_i   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .r_ready_i    (r_ready_o),
    .aw_addr_i    (aw_addr_o),
    .aw_cache_i   (aw_cache_o),
    .aw_valid_i   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .w_valid_i    (w_valid_o),
    .b_ready_i    (b_ready_o),
    .req_valid_i  (req_port.req_valid),
    .req_ready_i  (req_port.req_ready),
    .resp_valid_i (req_port.resp_valid)
);

/* cpu_bus_unit_tb.sv */
`timescale 1ns/100ps

module cpu_bus_unit_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int GROUP_LIMIT = 100;
    localparam int PHASE_LIMIT = 20;
    localparam int IDLE_LIMIT  = 50;

    typedef struct packed {
        logic                       port;
        logic                       pair;
        logic                       we;
        logic [bus_pkg::ADDR_W-1:0] vaddr;
        logic [bus_pkg::DATA_W-1:0] wdata;
        logic [bus_pkg::STRB_W-1:0] strb;
        logic [bus_pkg::DATA_W-1:0] rdata;
    } access_t;

    typedef struct packed {
        logic                       we;
        logic [bus_pkg::ADDR_W-1:0] addr;
        logic [3:0]                 cache;
        logic [bus_pkg::DATA_W-1:0] wdata;
        logic [bus_pkg::STRB_W-1:0] strb;
    } bus_exp_t;

    logic clk = 1'b0;
    logic rst;
    logic inst_valid_i, inst_ready_o, inst_resp_valid_o;
    logic [31:0] inst_addr_i, inst_rdata_o;
    logic data_valid_i, data_we_i, data_ready_o, data_resp_valid_o;
    logic [31:0] data_addr_i, data_wdata_i, data_rdata_o;
    logic [3:0] data_wstrb_i;
    logic [31:0] ar_addr_o, aw_addr_o, w_data_o, r_data_i;
    logic [3:0] ar_cache_o, aw_cache_o, w_strb_o;
    logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;

    logic [31:0] mem [logic [31:0]];
    bus_exp_t    exp_q [$];
    access_t     d_acc;
    access_t     i_acc;
    logic        d_pend, d_wait, i_pend, i_wait;
    logic        trace_done = 1'b0;
    int unsigned lcg_state = 80255;
    int          errors = 0;
    int          checks = 0;

    cpu_bus_unit dut (.*);

    initial begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_delay();
        return (next_random() >> 16) % 4;
    endfunction

    // kseg0 and kseg1 lose the top three bits, all other segments are unmapped
    function automatic logic [31:0] segment_paddr(bus_pkg::vaddr_u va);
        if (va.fields.seg == bus_pkg::SEG_KSEG0 || va.fields.seg == bus_pkg::SEG_KSEG1) begin
            return va.raw & 32'h1fff_ffff;
        end
        return va.raw;
    endfunction

    function automatic logic [3:0] segment_cache(bus_pkg::vaddr_u va);
        if (va.fields.seg == bus_pkg::SEG_KSEG1) begin
            return bus_pkg::CACHE_UNCACHED;
        end
        return bus_pkg::CACHE_CACHED;
    endfunction

    // words never written read back as the inverted address
    function automatic logic [31:0] mem_word(logic [31:0] a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    function automatic bus_exp_t bus_expect(access_t a);
        bus_exp_t e;
        e.we    = a.we && a.port;
        e.addr  = segment_paddr(a.vaddr);
        e.cache = segment_cache(a.vaddr);
        e.wdata = a.wdata;
        e.strb  = a.strb;
        return e;
    endfunction

    task automatic compare_word(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR t=%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic abort_run(string what);
        $display("ERROR t=%0t %s", $time, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic check_quiet();
        compare_word("{ar_valid_o,aw_valid_o,w_valid_o,r_ready_o,b_ready_o}", 0,
                     {ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o});
        compare_word("{inst_resp_valid_o,data_resp_valid_o,inst_ready_o,data_ready_o}", 0,
                     {inst_resp_valid_o, data_resp_valid_o, inst_ready_o, data_ready_o});
    endtask

    task automatic pop_expect(output bus_exp_t e);
        check_true(exp_q.size() > 0, "bus transaction without a pending request");
        e = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
    endtask

    task automatic serve_read();
        bus_exp_t    e;
        logic [31:0] addr;
        int          n;
        pop_expect(e);
        check_true(!e.we, "read on the bus where a write was expected");
        repeat (random_delay()) @(negedge clk);
        @(negedge clk);
        ar_ready_i = 1'b1;
        #(CLK_PERIOD/4);
        addr = ar_addr_o;
        compare_word("ar_addr_o", e.addr, ar_addr_o);
        compare_word("ar_cache_o", e.cache, ar_cache_o);
        @(negedge clk);
        ar_ready_i = 1'b0;
        repeat (random_delay()) @(negedge clk);
        r_valid_i = 1'b1;
        r_data_i  = mem_word(addr);
        n = 0;
        #(CLK_PERIOD/4);
        while (!r_ready_o) begin
            n++;
            if (n > PHASE_LIMIT) abort_run("timeout waiting for r_ready_o");
            @(negedge clk);
            #(CLK_PERIOD/4);
        end
        @(negedge clk);
        r_valid_i = 1'b0;
    endtask

    task automatic serve_write();
        bus_exp_t    e;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] word;
        logic [3:0]  strb;
        logic        aw_done;
        logic        w_done;
        int          d_aw;
        int          d_w;
        int          n;
        pop_expect(e);
        check_true(e.we, "write on the bus where a read was expected");
        d_aw    = random_delay();
        d_w     = random_delay();
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        // aw and w readies come independently, so either may finish first
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_ready_i = !aw_done && (n >= d_aw);
            w_ready_i  = !w_done && (n >= d_w);
            #(CLK_PERIOD/4);
            if (aw_ready_i && aw_valid_o) begin
                aw_done = 1'b1;
                addr    = aw_addr_o;
                compare_word("aw_addr_o", e.addr, aw_addr_o);
                compare_word("aw_cache_o", e.cache, aw_cache_o);
            end
            if (w_ready_i && w_valid_o) begin
                w_done = 1'b1;
                data   = w_data_o;
                strb   = w_strb_o;
                compare_word("w_data_o", e.wdata, w_data_o);
                compare_word("w_strb_o", e.strb, w_strb_o);
            end
            n++;
            if (n > PHASE_LIMIT) abort_run("timeout waiting for the aw and w handshakes");
        end
        @(negedge clk);
        aw_ready_i = 1'b0;
        w_ready_i  = 1'b0;
        word = mem_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[addr] = word;
        repeat (random_delay()) @(negedge clk);
        b_valid_i = 1'b1;
        n = 0;
        #(CLK_PERIOD/4);
        while (!b_ready_o) begin
            n++;
            if (n > PHASE_LIMIT) abort_run("timeout waiting for b_ready_o");
            @(negedge clk);
            #(CLK_PERIOD/4);
        end
        @(negedge clk);
        b_valid_i = 1'b0;
    endtask

    // AXI memory model, one transaction at a time
    initial begin : memory_model
        int idle;
        ar_ready_i = 1'b0;
        r_valid_i  = 1'b0;
        r_data_i   = '0;
        aw_ready_i = 1'b0;
        w_ready_i  = 1'b0;
        b_valid_i  = 1'b0;
        idle = 0;
        while (!trace_done) begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            if (ar_valid_o) begin
                idle = 0;
                serve_read();
            end else if (aw_valid_o) begin
                idle = 0;
                serve_write();
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) abort_run("timeout, no bus request arrived");
            end
        end
    end

    // drives the data and/or instruction request and collects their responses
    task automatic run_group();
        int   n;
        logic d_fire;
        logic i_fire;
        @(negedge clk);
        data_valid_i = d_pend;
        data_we_i    = d_acc.we;
        data_addr_i  = d_acc.vaddr;
        data_wdata_i = d_acc.wdata;
        data_wstrb_i = d_acc.strb;
        inst_valid_i = i_pend;
        inst_addr_i  = i_acc.vaddr;
        // data has priority, so its transaction is expected on the bus first
        if (d_pend) exp_q.push_back(bus_expect(d_acc));
        if (i_pend) exp_q.push_back(bus_expect(i_acc));
        n = 0;
        while (d_pend || d_wait || i_pend || i_wait) begin
            #(CLK_PERIOD/4);
            check_true(!(d_pend && inst_ready_o), "instruction port granted over a data request");
            d_fire = d_pend && data_ready_o;
            i_fire = i_pend && inst_ready_o;
            if (data_resp_valid_o) begin
                check_true(d_wait, "data response without an accepted data request");
                if (d_wait && !d_acc.we) compare_word("data_rdata_o", d_acc.rdata, data_rdata_o);
                d_wait = 1'b0;
            end
            if (inst_resp_valid_o) begin
                check_true(i_wait, "instruction response without an accepted fetch");
                if (i_wait) compare_word("inst_rdata_o", i_acc.rdata, inst_rdata_o);
                i_wait = 1'b0;
            end
            n++;
            if (n > GROUP_LIMIT) abort_run("timeout waiting for an access to complete");
            @(negedge clk);
            if (d_fire) begin
                d_pend       = 1'b0;
                d_wait       = 1'b1;
                data_valid_i = 1'b0;
            end
            if (i_fire) begin
                i_pend       = 1'b0;
                i_wait       = 1'b1;
                inst_valid_i = 1'b0;
            end
        end
    endtask

    task automatic read_access(input int fd, output access_t acc, output bit found);
        string       line;
        int          port;
        int          pair;
        int          we;
        int          n;
        logic [31:0] va;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [3:0]  st;
        found = 1'b0;
        acc   = '0;
        while (!found && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %h %h %h %h", port, pair, we, va, wd, st, rd);
                if (n == 7) begin
                    acc.port  = port[0];
                    acc.pair  = pair[0];
                    acc.we    = we[0];
                    acc.vaddr = va;
                    acc.wdata = wd;
                    acc.strb  = st;
                    acc.rdata = rd;
                    found     = 1'b1;
                end
            end
        end
    endtask

    initial begin : driver
        int      fd;
        int      test_no;
        int      errs_before;
        bit      found;
        access_t acc;
        access_t partner;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_addr_i  = '0;
        data_valid_i = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_wstrb_i = '0;
        d_pend = 1'b0;
        d_wait = 1'b0;
        i_pend = 1'b0;
        i_wait = 1'b0;
        d_acc  = '0;
        i_acc  = '0;
        test_no = 0;

        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (c == 7) rst = 1'b0;
            #(CLK_PERIOD/4);
            check_quiet();
        end
        @(negedge clk);
        #(CLK_PERIOD/4);
        check_quiet();
        $display("test 0 reset: %s", errors == 0 ? "ok" : "FAILED");

        fd = $fopen("bus_trace.txt", "r");
        if (fd == 0) abort_run("bus_trace.txt could not be opened");
        read_access(fd, acc, found);
        while (found) begin
            errs_before = errors;
            d_pend = acc.port;
            i_pend = !acc.port;
            if (acc.port) d_acc = acc;
            else i_acc = acc;
            if (acc.pair) begin
                read_access(fd, partner, found);
                check_true(found && acc.port && !partner.port,
                           "trace pair is not a data line followed by an instruction line");
                i_acc  = partner;
                i_pend = found && !partner.port;
            end
            run_group();
            test_no++;
            $display("test %0d %s %s vaddr %h: %s", test_no,
                     acc.pair ? "data+inst" : (acc.port ? "data" : "inst"),
                     acc.we ? "write" : "read", acc.vaddr,
                     errors == errs_before ? "ok" : "FAILED");
            read_access(fd, acc, found);
        end
        $fclose(fd);
        trace_done = 1'b1;

        // a late or doubled response pulse would show here
        repeat (10) begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            check_true(!data_resp_valid_o && !inst_resp_valid_o,
                       "response pulse after the last access");
        end
        check_true(exp_q.size() == 0, "requests that never appeared on the bus");
        $display("%0d tests, %0d checks, %0d errors", test_no + 1, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* bus_trace.txt */
# port(0 inst, 1 data) pair(1: issued with the next line) we vaddr wdata strb expected_rdata
# kseg0/kseg1 map to vaddr & 1fffffff, kseg1 is uncached, unwritten words read as ~paddr
1 0 1 80001000 11223344 f 00000000
1 0 0 a0001000 00000000 0 11223344
1 0 1 a0001004 deadbeef f 00000000
1 0 1 80001004 0000aa00 2 00000000
1 0 0 80001004 00000000 0 deadaaef
1 0 1 00400000 cafef00d f 00000000
0 0 0 00400000 00000000 0 cafef00d
1 0 1 80002000 24020001 f 00000000
0 0 0 80002000 00000000 0 24020001
1 0 1 c0003000 12345678 c 00000000
1 0 0 c0003000 00000000 0 1234cfff
0 0 0 9fc00000 00000000 0 e03fffff
1 1 0 80001000 00000000 0 11223344
0 0 0 80002000 00000000 0 24020001
1 1 1 a0005000 55667788 f 00000000
0 0 0 00400000 00000000 0 cafef00d
1 0 0 80005000 00000000 0 55667788
1 0 1 80001000 000000ff 1 00000000
0 0 0 a0001000 00000000 0 112233ff
1 1 0 a0001004 00000000 0 deadaaef
0 0 0 bfc00000 00000000 0 e03fffff
1 0 1 7ffffffc 87654321 3 00000000
1 0 0 7ffffffc 00000000 0 80004321

/* cpu_bus_unit.f */
bus_pkg.sv
mem_req_if.sv
addr_xlate.sv
mem_arbiter.sv
axi_bridge.sv
cpu_bus_unit.sv
cpu_bus_unit_properties.sv
cpu_bus_unit_tb.sv

/* Bender.yml */
package:
  name: cpu_bus_unit

sources:
  - bus_pkg.sv
  - mem_req_if.sv
  - addr_xlate.sv
  - mem_arbiter.sv
  - axi_bridge.sv
  - cpu_bus_unit.sv
  - target: test
    files:
      - cpu_bus_unit_properties.sv
      - cpu_bus_unit_tb.sv
